//--- dtim.f
src/dtim_pkg.sv
src/dtim_ram.sv
src/dtim_front.sv
src/dtim_ctrl.sv
src/dtim.sv
tb/dtim_clock.sv
tb/dtim_sva.sv
tb/dtim_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module dtim_tb -f dtim.f -o dtim_sim
./obj_dir/dtim_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
# a run that stopped on an assertion never reaches the pass line.
grep -q "STATUS: PASS" sim.log

//--- src/dtim.sv
`timescale 1ns/10ps

module dtim import dtim_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  dtim_req_t req,
  output dtim_rsp_t rsp,
  output mem_req_t  mem_req,
  input  mem_rsp_t  mem_rsp
);

  front_t front_next;
  front_t front_cur;
  ram_in_t ram_in [dtim_banks];
  ram_out_t ram_out [dtim_banks];

  for (genvar i = 0; i < dtim_banks; i++) begin : g_bank
    dtim_ram i_ram (
      .clock   (clock),
      .ram_in  (ram_in[i]),
      .ram_out (ram_out[i])
    );
  end

  dtim_front i_front (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .front_next (front_next),
    .front_cur  (front_cur)
  );

  dtim_ctrl i_ctrl (
    .clock      (clock),
    .reset      (reset),
    .front_next (front_next),
    .front_cur  (front_cur),
    .ram_in     (ram_in),
    .ram_out    (ram_out),
    .rsp        (rsp),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp)
  );

endmodule

//--- src/dtim_ctrl.sv
`timescale 1ns/10ps

module dtim_ctrl import dtim_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  front_t    front_next,
  input  front_t    front_cur,
  output ram_in_t   ram_in [dtim_banks],
  input  ram_out_t  ram_out [dtim_banks],
  output dtim_rsp_t rsp,
  output mem_req_t  mem_req,
  input  mem_rsp_t  mem_rsp
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  front_t cur_q; // request parked across a memory access.
  logic pending_q;
  logic pending_d;
  logic [set_bits+bank_bits-1:0] walk_q;
  logic [set_bits+bank_bits-1:0] walk_d;

  logic [set_bits-1:0] walk_set;
  logic [bank_bits-1:0] walk_bank;
  dtim_entry_t entry;
  dtim_entry_t walk_entry;

  logic in_window;
  logic is_fence;
  logic is_pass;
  logic is_miss;
  logic is_hit;

  logic wen;
  logic [bank_bits-1:0] wbank;
  logic [set_bits-1:0] wset;
  dtim_entry_t wentry;

  assign walk_set = walk_q[bank_bits +: set_bits];
  assign walk_bank = walk_q[bank_bits-1:0];
  assign entry = ram_out[front_cur.bank].rdata; // bank read started a cycle earlier.
  assign walk_entry = ram_out[walk_bank].rdata;

  assign in_window = (front_cur.addr >= dtim_base_addr) && (front_cur.addr < dtim_top_addr);

  // ##########################################################
  // request classification
  // ##########################################################

  always_comb begin
    is_fence = 1'b0;
    is_pass = 1'b0;
    is_miss = 1'b0;
    is_hit = 1'b0;
    if (state_q == st_hit && front_cur.enable) begin
      if (front_cur.fence) begin
        is_fence = 1'b1;
      end else if (!in_window || (entry.lock && entry.tag != front_cur.tag)) begin
        is_pass = 1'b1; // line owned by another tag.
      end else if (!entry.lock) begin
        is_miss = 1'b1;
      end else begin
        is_hit = 1'b1;
      end
    end
  end

  // ##########################################################
  // state machine
  // ##########################################################

  always_comb begin
    state_d = state_q;
    pending_d = pending_q;
    walk_d = walk_q;
    rsp = '0;
    mem_req = '0;
    wen = 1'b0;
    wbank = '0;
    wset = '0;
    wentry = '0;

    case (state_q)
      st_hit: begin
        if (is_fence) begin
          walk_d = '0;
          pending_d = 1'b0;
          state_d = st_fence;
        end else if (is_pass) begin
          mem_req.valid = 1'b1;
          mem_req.addr = front_cur.addr;
          mem_req.wdata = front_cur.data;
          mem_req.wstrb = front_cur.strb;
          state_d = st_ldst;
        end else if (is_miss) begin
          mem_req.valid = 1'b1; // word fetch, store bytes merged on return.
          mem_req.addr = front_cur.addr;
          state_d = st_miss;
        end else if (is_hit) begin
          rsp.ready = 1'b1;
          rsp.rdata = front_cur.wren ? '0 : entry.data;
          wen = front_cur.wren;
          wbank = front_cur.bank;
          wset = front_cur.set;
          wentry.lock = 1'b1;
          wentry.dirty = 1'b1;
          wentry.tag = front_cur.tag;
          wentry.data = merge_bytes(entry.data, front_cur.data, front_cur.strb);
        end
      end

      st_miss: begin
        if (mem_rsp.ready) begin
          rsp.ready = 1'b1;
          rsp.rdata = mem_rsp.rdata;
          wen = 1'b1; // allocate the line.
          wbank = cur_q.bank;
          wset = cur_q.set;
          wentry.lock = 1'b1;
          wentry.dirty = cur_q.wren;
          wentry.tag = cur_q.tag;
          wentry.data = merge_bytes(mem_rsp.rdata, cur_q.data, cur_q.strb);
          state_d = st_hit;
        end
      end

      st_ldst: begin
        if (mem_rsp.ready) begin
          rsp.ready = 1'b1;
          rsp.rdata = mem_rsp.rdata;
          state_d = st_hit;
        end
      end

      st_fence: begin
        if (!pending_q && walk_entry.lock && walk_entry.dirty) begin
          mem_req.valid = 1'b1; // write back the whole word.
          mem_req.addr = {walk_entry.tag, walk_set, walk_bank, 2'b00};
          mem_req.wdata = walk_entry.data;
          mem_req.wstrb = 4'hf;
          pending_d = 1'b1;
        end else if (!pending_q || mem_rsp.ready) begin
          pending_d = 1'b0;
          wen = 1'b1; // clear the line.
          wbank = walk_bank;
          wset = walk_set;
          if (&walk_q) begin
            rsp.ready = 1'b1;
            state_d = st_hit;
          end else begin
            walk_d = walk_q + 1'b1;
          end
        end
      end

      default: begin
        state_d = st_hit;
      end
    endcase
  end

  // ##########################################################
  // bank port steering
  // ##########################################################

  always_comb begin
    for (int b = 0; b < dtim_banks; b++) begin
      ram_in[b] = '0;
    end
    if (front_next.enable) begin
      ram_in[front_next.bank].raddr = front_next.set; // lookup starts with the request.
    end
    if (state_d == st_fence) begin
      ram_in[walk_d[bank_bits-1:0]].raddr = walk_d[bank_bits +: set_bits];
    end
    if (wen) begin
      ram_in[wbank].wen = 1'b1;
      ram_in[wbank].waddr = wset;
      ram_in[wbank].wdata = wentry;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= st_hit;
      pending_q <= 1'b0;
      walk_q <= '0;
    end else begin
      state_q <= state_d;
      pending_q <= pending_d;
      walk_q <= walk_d;
    end
  end

  always_ff @(posedge clock) begin
    if (is_pass || is_miss) begin
      cur_q <= front_cur;
    end
  end

endmodule

//--- src/dtim_front.sv
`timescale 1ns/10ps

module dtim_front import dtim_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  dtim_req_t req,
  output front_t    front_next,
  output front_t    front_cur
);

  // ##########################################################
  // request decode
  // ##########################################################

  always_comb begin
    front_next.enable = req.valid;
    front_next.fence = req.valid & req.fence;
    front_next.wren = req.valid & (|req.wstrb); // any strobe makes a store.
    front_next.addr = {req.addr[31:2], 2'b00};
    front_next.data = req.wdata;
    front_next.strb = req.wstrb;
    front_next.tag = req.addr[31 -: tag_bits];
    front_next.set = req.addr[2+bank_bits +: set_bits];
    front_next.bank = req.addr[2 +: bank_bits]; // word interleave across banks.
  end

  // ##########################################################
  // request register
  // ##########################################################

  always_ff @(posedge clock) begin
    if (!reset) begin
      front_cur <= '0;
    end else begin
      front_cur <= front_next;
    end
  end

endmodule

//--- src/dtim_pkg.sv
package dtim_pkg;

  // ##########################################################
  // sizes and address window
  // ##########################################################

  localparam int dtim_banks = 4;
  localparam int dtim_sets = 16;
  localparam int bank_bits = 2;
  localparam int set_bits = 4;
  localparam int tag_bits = 32 - set_bits - bank_bits - 2; // above set, bank and byte offset.

  localparam logic [31:0] dtim_base_addr = 32'h0000_0000;
  localparam logic [31:0] dtim_top_addr = 32'h0000_1000; // first address past the window.

  // ##########################################################
  // types
  // ##########################################################

  typedef enum logic [1:0] {
    st_hit,
    st_miss,
    st_ldst,
    st_fence
  } ctrl_state_t;

  typedef struct packed {
    logic valid;
    logic fence;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] wstrb; // zero for a read.
  } dtim_req_t;

  typedef struct packed {
    logic ready;
    logic [31:0] rdata;
  } dtim_rsp_t;

  typedef struct packed {
    logic valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic lock; // line valid.
    logic dirty;
    logic [tag_bits-1:0] tag;
    logic [31:0] data;
  } dtim_entry_t;

  typedef struct packed {
    logic wen;
    logic [set_bits-1:0] waddr;
    logic [set_bits-1:0] raddr;
    dtim_entry_t wdata;
  } ram_in_t;

  typedef struct packed {
    dtim_entry_t rdata;
  } ram_out_t;

  typedef struct packed {
    logic enable;
    logic fence;
    logic wren;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0] strb;
    logic [tag_bits-1:0] tag;
    logic [set_bits-1:0] set;
    logic [bank_bits-1:0] bank;
  } front_t;

  // takes a byte from new_word wherever its strobe bit is set.
  function automatic logic [31:0] merge_bytes(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [3:0] strb
  );
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return result;
  endfunction

endpackage

//--- src/dtim_ram.sv
`timescale 1ns/10ps

module dtim_ram import dtim_pkg::*; (
  input  logic     clock,
  input  ram_in_t  ram_in,
  output ram_out_t ram_out
);

  dtim_entry_t lines [dtim_sets] = '{default: '0}; // all lines start unlocked.

  logic [set_bits-1:0] raddr_q = '0;

  always_ff @(posedge clock) begin
    raddr_q <= ram_in.raddr;
    if (ram_in.wen) begin
      lines[ram_in.waddr] <= ram_in.wdata;
    end
  end

  // a write at the same edge as the address shows up here next cycle.
  assign ram_out.rdata = lines[raddr_q];

endmodule

//--- tb/dtim_clock.sv
`timescale 1ns/10ps

module dtim_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock; // 10 ns period.
  end

  initial begin
    reset = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b1;
  end

endmodule

//--- tb/dtim_sva.sv
`timescale 1ns/10ps

module dtim_sva import dtim_pkg::*; (
  input logic        clock,
  input logic        reset,
  input ctrl_state_t state_q,
  input front_t      front_cur,
  input dtim_entry_t entry,
  input dtim_rsp_t   rsp,
  input mem_req_t    mem_req,
  input mem_rsp_t    mem_rsp
);

  logic mem_busy; // a memory request is waiting for its ready.
  logic lookup_hit; // request finds its own tag in a locked line.

  always_ff @(posedge clock) begin
    if (!reset) begin
      mem_busy <= 1'b0;
    end else if (mem_req.valid) begin
      mem_busy <= 1'b1;
    end else if (mem_rsp.ready) begin
      mem_busy <= 1'b0;
    end
  end

  assign lookup_hit = front_cur.enable && !front_cur.fence && entry.lock &&
                      (entry.tag == front_cur.tag) &&
                      (front_cur.addr >= dtim_base_addr) && (front_cur.addr < dtim_top_addr);

  ready_pulse: assert property (@(posedge clock) disable iff (!reset)
    rsp.ready |=> !rsp.ready)
    else $error("rsp.ready high on two cycles in a row");

  single_outstanding: assert property (@(posedge clock) disable iff (!reset)
    mem_req.valid |-> !mem_busy)
    else $error("mem_req.valid issued before the previous mem_rsp.ready");

  hit_stays_local: assert property (@(posedge clock) disable iff (!reset)
    (state_q == st_hit && lookup_hit) |-> (rsp.ready && !mem_req.valid))
    else $error("hit went to memory or gave no ready");

endmodule

bind dtim_ctrl dtim_sva i_sva (
  .clock     (clock),
  .reset     (reset),
  .state_q   (state_q),
  .front_cur (front_cur),
  .entry     (entry),
  .rsp       (rsp),
  .mem_req   (mem_req),
  .mem_rsp   (mem_rsp)
);

//--- tb/dtim_tb.sv
`timescale 1ns/10ps

module dtim_tb import dtim_pkg::*; ();

  localparam int num_lines = dtim_banks * dtim_sets;
  localparam int num_requests = 19 + num_lines; // directed accesses and fences, plus the fill.
  localparam int watchdog_cycles = num_requests * 10 + 2 * dtim_banks * dtim_sets * 6;
  localparam int ready_limit = num_lines * 8;

  logic clock;
  logic reset;
  dtim_req_t req;
  dtim_rsp_t rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp;

  logic [31:0] backing [logic [31:0]]; // keyed by word-aligned address.
  int mem_reads;
  int mem_writes;

  logic line_lock [num_lines];
  logic line_dirty [num_lines];
  logic [tag_bits-1:0] line_tag [num_lines];
  logic [31:0] line_data [num_lines];

  dtim_clock i_clock (
    .clock (clock),
    .reset (reset)
  );

  dtim i_dut (
    .clock   (clock),
    .reset   (reset),
    .req     (req),
    .rsp     (rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  // ##########################################################
  // reporting
  // ##########################################################

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[ERROR] %0t %s: got 0x%08h, expected 0x%08h",
        $time, name, actual, expected));
    end
  endtask

  // ##########################################################
  // backing memory
  // ##########################################################

  function automatic logic [31:0] backing_word(input logic [31:0] addr);
    if (backing.exists(addr)) begin
      return backing[addr];
    end
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  task automatic serve_memory();
    logic [31:0] addr;
    logic [31:0] word;
    int delay;
    forever begin
      @(negedge clock);
      if (mem_req.valid) begin
        addr = {mem_req.addr[31:2], 2'b00};
        word = backing_word(addr);
        if (mem_req.wstrb != 4'h0) begin
          backing[addr] = merge_bytes(word, mem_req.wdata, mem_req.wstrb);
          mem_writes++;
          word = '0;
        end else begin
          mem_reads++;
        end
        delay = $urandom_range(4, 1);
        repeat (delay) @(posedge clock);
        mem_rsp <= '{ready: 1'b1, rdata: word};
        @(posedge clock);
        mem_rsp <= '0;
      end
    end
  endtask

  initial begin
    mem_rsp = '0;
    serve_memory();
  end

  // ##########################################################
  // line model
  // ##########################################################

  task automatic clear_model();
    for (int i = 0; i < num_lines; i++) begin
      line_lock[i] = 1'b0;
      line_dirty[i] = 1'b0;
      line_tag[i] = '0;
      line_data[i] = '0;
    end
  endtask

  task automatic predict(input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb, output logic [31:0] exp_rdata,
                         output int exp_reads, output int exp_writes, output logic exp_hit);
    int idx;
    logic [tag_bits-1:0] tag;
    logic [31:0] word;
    idx = int'(addr[2 +: set_bits + bank_bits]);
    tag = addr[31 -: tag_bits];
    word = backing_word(addr);
    exp_rdata = word;
    exp_reads = 0;
    exp_writes = 0;
    exp_hit = 1'b0;
    if (addr < dtim_base_addr || addr >= dtim_top_addr ||
        (line_lock[idx] && line_tag[idx] != tag)) begin
      if (wstrb != 4'h0) begin
        exp_writes = 1;
      end else begin
        exp_reads = 1;
      end
    end else if (!line_lock[idx]) begin
      exp_reads = 1; // fetch, then allocate.
      line_lock[idx] = 1'b1;
      line_dirty[idx] = (wstrb != 4'h0);
      line_tag[idx] = tag;
      line_data[idx] = merge_bytes(word, wdata, wstrb);
    end else begin
      exp_hit = 1'b1;
      exp_rdata = line_data[idx];
      if (wstrb != 4'h0) begin
        line_dirty[idx] = 1'b1;
        line_data[idx] = merge_bytes(line_data[idx], wdata, wstrb);
      end
    end
  endtask

  // ##########################################################
  // request driving
  // ##########################################################

  task automatic send_request(input logic is_fence, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] wstrb,
                              output logic [31:0] rdata, output int latency);
    @(posedge clock);
    req <= '{valid: 1'b1, fence: is_fence, addr: addr, wdata: wdata, wstrb: wstrb};
    @(posedge clock);
    req <= '0;
    latency = 1;
    @(negedge clock);
    while (!rsp.ready) begin
      if (latency >= ready_limit) begin
        stop_with_failure($sformatf("no ready from the DUT %0d cycles after the request",
          latency));
      end
      @(negedge clock);
      latency++;
    end
    rdata = rsp.rdata;
  endtask

  task automatic access_and_check(input logic [31:0] addr, input logic [31:0] wdata,
                                  input logic [3:0] wstrb);
    logic [31:0] exp_rdata;
    logic [31:0] exp_word;
    logic [31:0] rdata;
    logic exp_hit;
    int exp_reads;
    int exp_writes;
    int reads_before;
    int writes_before;
    int latency;
    exp_word = backing_word(addr);
    predict(addr, wdata, wstrb, exp_rdata, exp_reads, exp_writes, exp_hit);
    if (exp_writes != 0) begin
      exp_word = merge_bytes(exp_word, wdata, wstrb);
    end
    reads_before = mem_reads;
    writes_before = mem_writes;
    send_request(1'b0, addr, wdata, wstrb, rdata, latency);
    if (wstrb == 4'h0) begin
      check("rsp.rdata", rdata, exp_rdata);
    end
    if (exp_hit) begin
      check("hit latency", latency, 1);
    end
    check("memory reads", mem_reads - reads_before, exp_reads);
    check("memory writes", mem_writes - writes_before, exp_writes);
    check($sformatf("backing word at 0x%08h", addr), backing_word(addr), exp_word);
  endtask

  task automatic fence_and_check();
    logic [31:0] rdata;
    logic [31:0] line_addr;
    int dirty_lines;
    int reads_before;
    int writes_before;
    int latency;
    dirty_lines = 0;
    for (int i = 0; i < num_lines; i++) begin
      if (line_lock[i] && line_dirty[i]) begin
        dirty_lines++;
      end
    end
    reads_before = mem_reads;
    writes_before = mem_writes;
    send_request(1'b1, '0, '0, 4'h0, rdata, latency);
    check("fence rsp.rdata", rdata, '0);
    check("fence memory writes", mem_writes - writes_before, dirty_lines);
    check("fence memory reads", mem_reads - reads_before, 0);
    for (int i = 0; i < num_lines; i++) begin
      if (line_lock[i] && line_dirty[i]) begin
        line_addr = {line_tag[i], 8'h00} | (32'(i) << 2);
        check($sformatf("backing word at 0x%08h", line_addr), backing_word(line_addr),
          line_data[i]);
      end
    end
    clear_model();
  endtask

  // ##########################################################
  // tests
  // ##########################################################

  task automatic read_miss_then_hit();
    access_and_check(32'h0000_0104, '0, 4'h0); // cold line.
    access_and_check(32'h0000_0104, '0, 4'h0);
  endtask

  task automatic write_hit_merge();
    access_and_check(32'h0000_0104, 32'ha1b2_c3d4, 4'b0101);
    access_and_check(32'h0000_0104, '0, 4'h0);
  endtask

  task automatic write_miss_allocate();
    access_and_check(32'h0000_0238, 32'h5566_7788, 4'b1100);
    access_and_check(32'h0000_0238, '0, 4'h0);
  endtask

  task automatic pass_through();
    access_and_check(32'h0000_2010, '0, 4'h0); // outside the window.
    access_and_check(32'h0000_3020, 32'hdead_beef, 4'hf);
    access_and_check(32'h0000_0504, '0, 4'h0); // same line as 0x104, other tag.
    access_and_check(32'h0000_0504, 32'h0bad_f00d, 4'b0011);
    access_and_check(32'h0000_0104, '0, 4'h0);
  endtask

  task automatic fence_writeback();
    access_and_check(32'h0000_03c0, '0, 4'h0);
    access_and_check(32'h0000_0048, 32'h1234_5678, 4'hf);
    access_and_check(32'h0000_008c, 32'h00c3_0000, 4'b0100);
    fence_and_check();
    access_and_check(32'h0000_0104, '0, 4'h0); // written back, now a miss.
    access_and_check(32'h0000_0238, '0, 4'h0);
  endtask

  task automatic fence_all_lines();
    for (int i = 0; i < num_lines; i++) begin
      access_and_check(32'h0000_0f00 + 32'(i) * 4, $urandom, 4'hf);
    end
    fence_and_check();
    access_and_check(32'h0000_0f10, '0, 4'h0);
  endtask

  initial begin
    void'($urandom(32'hbdcc));
    req = '0;
    mem_reads = 0;
    mem_writes = 0;
    for (int a = 0; a < int'(dtim_top_addr >> 2); a++) begin
      backing[dtim_base_addr + 32'(a) * 4] = $urandom;
    end
    clear_model();
    wait (reset === 1'b1);
    repeat (2) @(posedge clock);
    read_miss_then_hit();
    write_hit_merge();
    write_miss_allocate();
    pass_through();
    fence_writeback();
    fence_all_lines();
    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    stop_with_failure($sformatf("run still busy after %0d cycles", watchdog_cycles));
  end

endmodule
